//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT      := --lint-only --timing -Wall
TOP       := ps2_keyboard_rx_tb
RTL_TOP   := ps2_keyboard_rx
FILELIST  := ps2_keyboard_rx.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/key_event_buffer.sv
// output register for key events and the ready/read handshake with the host
`timescale 1ns/1ps

module key_event_buffer
  import key_event_pkg::*;
(
  input  logic       clk,
  input  logic       reset,        // sync, active low
  input  key_event_t event_in,
  input  logic       event_valid,  // one cycle, load event_in
  input  logic       key_read,     // host has taken key_event
  output key_event_t key_event,
  output logic       key_ready
);

  typedef enum logic {
    WAIT_EVENT = 1'b0,  // nothing pending
    HOLD_EVENT = 1'b1   // key_event not yet read
  } ready_state_t;

  ready_state_t state;
  ready_state_t next_state;

  // newest event always wins, the keyboard cannot be held off
  always_ff @(posedge clk)
  begin
    if (!reset)
      key_event <= '0;
    else if (event_valid)
      key_event <= event_in;
  end

  //----------------------------------------
  // ready fsm
  //----------------------------------------

  always_comb
  begin
    next_state = state;
    if (event_valid)
      next_state = HOLD_EVENT;   // also beats a read in the same cycle
    else if (key_read)
      next_state = WAIT_EVENT;
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      state <= WAIT_EVENT;
    else
      state <= next_state;
  end

  assign key_ready = (state == HOLD_EVENT);

endmodule

//--- logic/key_event_pkg.sv
// host-side types for key events; imported wherever a scan code, ascii byte or key event is used
package key_event_pkg;

  //----------------------------------------
  // basic byte types
  //----------------------------------------

  typedef logic [7:0] scan_code_t;  // raw keyboard scan code
  typedef logic [7:0] ascii_t;      // translated character

  // translation result for any code missing from the table ('.')
  localparam ascii_t ASCII_UNLISTED = 8'h2E;

  //----------------------------------------
  // one finished key event as seen by the host
  //----------------------------------------

  typedef struct packed {
    logic       extended;  // E0 prefix came before this code
    logic       released;  // F0 prefix came before this code
    logic       shift_on;  // shift state before this code was taken
    scan_code_t scan;      // the scan code itself
    ascii_t     ascii;     // table lookup of scan under shift_on
  } key_event_t;

endpackage

//--- logic/ps2_frame_receiver.sv
// synchronizes the ps/2 clock and data lines and assembles 11-bit frames, one strobe per frame
`timescale 1ns/1ps

module ps2_frame_receiver
  import ps2_protocol_pkg::*;
(
  input  logic       clk,
  input  logic       reset,       // sync, active low
  input  logic       ps2_clk,     // async from keyboard, idle high
  input  logic       ps2_data,    // async from keyboard, idle high
  output ps2_frame_t frame,       // valid while frame_done is high
  output logic       frame_done   // one cycle, eleventh bit is in
);

  logic [1:0]               clk_sync;    // [1] is the usable copy
  logic [1:0]               data_sync;
  logic                     clk_prev;    // synced clock one cycle late
  logic                     fall_edge;
  bit_count_t               bit_count;
  logic [WATCHDOG_BITS-1:0] wd_count;
  logic                     wd_expired;

  //----------------------------------------
  // input synchronizers
  //----------------------------------------

  // reset to idle high so no false edge comes out of reset
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end
    else
    begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};  // same delay as the clock
      clk_prev  <= clk_sync[1];
    end
  end

  assign fall_edge = clk_prev & ~clk_sync[1];  // keyboard drives data before it drops clk

  //----------------------------------------
  // shift register and bit counter
  //----------------------------------------

  // new bit enters at the top, so the start bit ends in bit 0
  always_ff @(posedge clk)
  begin
    if (fall_edge)
      frame <= ps2_frame_t'({data_sync[1], frame[FRAME_BITS-1:1]});
  end

  // the watchdog is still expired on the first fall after a long idle,
  // so an edge has to win over it or the start bit would be lost
  always_ff @(posedge clk)
  begin
    if (!reset)
      bit_count <= '0;
    else if (frame_done)                 // end of frame
      bit_count <= '0;
    else if (fall_edge)
      bit_count <= bit_count + 1'b1;
    else if (wd_expired)                 // stale partial frame
      bit_count <= '0;
  end

  assign frame_done = (bit_count == bit_count_t'(FRAME_BITS));

  //----------------------------------------
  // idle watchdog
  //----------------------------------------

  // counts clk cycles of high ps2 clock, saturates at the limit
  // a plugged-in keyboard mid-frame thus cannot leave the counter off by some bits
  always_ff @(posedge clk)
  begin
    if (!reset)
      wd_count <= '0;
    else if (!clk_sync[1])
      wd_count <= '0;                    // any low restarts the count
    else if (!wd_expired)
      wd_count <= wd_count + 1'b1;
  end

  assign wd_expired = (wd_count == WATCHDOG_BITS'(WATCHDOG_CYCLES));

endmodule

//--- logic/ps2_keyboard_rx.sv
// top of the receive-only ps/2 keyboard interface; frames in from the keyboard, key events out to the host
`timescale 1ns/1ps

module ps2_keyboard_rx
  import key_event_pkg::*;
  import ps2_protocol_pkg::*;
(
  input  logic       clk,
  input  logic       reset,      // sync, active low
  input  logic       ps2_clk,    // keyboard clock, input only
  input  logic       ps2_data,   // keyboard data, input only
  input  logic       key_read,   // host acknowledge
  output key_event_t key_event,
  output logic       key_ready
);

  ps2_frame_t frame;
  logic       frame_done;
  logic       shift_on;
  ascii_t     ascii;
  key_event_t event_out;
  logic       event_valid;

  //----------------------------------------
  // receive chain
  //----------------------------------------

  ps2_frame_receiver u_frame_receiver (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .frame      (frame),
    .frame_done (frame_done)
  );

  scan_code_tracker u_code_tracker (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_done  (frame_done),
    .ascii       (ascii),
    .shift_on    (shift_on),
    .event_out   (event_out),
    .event_valid (event_valid)
  );

  // lookup runs on the raw frame data, ahead of the event register
  scan_to_ascii u_scan_to_ascii (
    .scan     (frame.data),
    .shift_on (shift_on),
    .ascii    (ascii)
  );

  key_event_buffer u_event_buffer (
    .clk         (clk),
    .reset       (reset),
    .event_in    (event_out),
    .event_valid (event_valid),
    .key_read    (key_read),
    .key_event   (key_event),
    .key_ready   (key_ready)
  );

endmodule

//--- logic/ps2_protocol_pkg.sv
// ps/2 line protocol constants and frame layout; imported by the frame receiver and the code tracker
package ps2_protocol_pkg;

  import key_event_pkg::*;  // frame payload is a scan code

  localparam int FRAME_BITS = 11;  // start + 8 data + parity + stop

  // prefix and modifier codes sent by the keyboard
  localparam scan_code_t EXTEND_CODE      = 8'hE0;
  localparam scan_code_t RELEASE_CODE     = 8'hF0;
  localparam scan_code_t LEFT_SHIFT_CODE  = 8'h12;
  localparam scan_code_t RIGHT_SHIFT_CODE = 8'h59;

  // idle watchdog, about 60 us at 49.152 MHz
  localparam int WATCHDOG_CYCLES = 2950;
  localparam int WATCHDOG_BITS   = 12;   // enough for WATCHDOG_CYCLES

  typedef logic [3:0] bit_count_t;  // counts 0..FRAME_BITS

  // frame as it sits in the shift register once all bits are in
  // (first bit on the wire ends up in the lsb)
  typedef struct packed {
    logic       stop;    // always 1 on the wire
    logic       parity;  // odd parity, not checked
    scan_code_t data;    // lsb first on the wire
    logic       start;   // always 0 on the wire
  } ps2_frame_t;

endpackage

//--- logic/scan_code_tracker.sv
// follows the e0/f0 prefixes and shift keys across frames and issues one event per key code
`timescale 1ns/1ps

module scan_code_tracker
  import key_event_pkg::*;
  import ps2_protocol_pkg::*;
(
  input  logic       clk,
  input  logic       reset,        // sync, active low
  input  ps2_frame_t frame,
  input  logic       frame_done,
  input  ascii_t     ascii,        // lookup result for frame.data
  output logic       shift_on,     // to the ascii table
  output key_event_t event_out,
  output logic       event_valid   // one cycle, key code finished
);

  logic is_extend;
  logic is_release;
  logic hold_extended;   // e0 seen, waiting for the key code
  logic hold_released;   // f0 seen, waiting for the key code
  logic left_shift;
  logic right_shift;

  // prefix decode on the current frame
  assign is_extend  = (frame.data == EXTEND_CODE);
  assign is_release = (frame.data == RELEASE_CODE);

  // a prefix only arms a flag, anything else completes the event
  assign event_valid = frame_done & ~is_extend & ~is_release;

  //----------------------------------------
  // prefix flags
  //----------------------------------------

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (event_valid)
    begin
      hold_extended <= 1'b0;  // consumed by this event
      hold_released <= 1'b0;
    end
    else if (frame_done)
    begin
      if (is_extend)
        hold_extended <= 1'b1;
      if (is_release)
        hold_released <= 1'b1;
    end
  end

  //----------------------------------------
  // shift key state
  //----------------------------------------

  // make sets the flag, break (f0 prefix) clears it
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
    end
    else if (frame_done)
    begin
      if (frame.data == LEFT_SHIFT_CODE)
        left_shift <= ~hold_released;
      if (frame.data == RIGHT_SHIFT_CODE)
        right_shift <= ~hold_released;
    end
  end

  assign shift_on = left_shift | right_shift;  // old value while the shift code itself goes out

  // event fields, all taken before this frame updates the flags
  assign event_out = '{extended: hold_extended,
                       released: hold_released,
                       shift_on: shift_on,
                       scan:     frame.data,
                       ascii:    ascii};

endmodule

//--- logic/scan_to_ascii.sv
// combinational scan code to ascii lookup, upper or lower case picked by the shift state
`timescale 1ns/1ps

module scan_to_ascii
  import key_event_pkg::*;
(
  input  scan_code_t scan,
  input  logic       shift_on,
  output ascii_t     ascii
);

  logic [11:0] table_key;  // {3'b0, shift, scan}, one hex digit per field

  assign table_key = {3'b000, shift_on, scan};

  // entries sorted by ascii value, ? in the top digit means either shift state
  always_comb
  begin
    casez (table_key)
      12'h?66 : ascii = 8'h08;  // backspace
      12'h?0D : ascii = 8'h09;  // tab
      12'h?5A : ascii = 8'h0D;  // enter
      12'h?76 : ascii = 8'h1B;  // escape
      12'h?29 : ascii = 8'h20;  // space
      12'h116 : ascii = 8'h21;  // !
      12'h152 : ascii = 8'h22;  // double quote
      12'h126 : ascii = 8'h23;  // #
      12'h125 : ascii = 8'h24;  // $
      12'h12E : ascii = 8'h25;  // %
      12'h13D : ascii = 8'h26;  // &
      12'h052 : ascii = 8'h27;  // single quote
      12'h146 : ascii = 8'h28;  // (
      12'h145 : ascii = 8'h29;  // )
      12'h13E : ascii = 8'h2A;  // *
      12'h155 : ascii = 8'h2B;  // +
      12'h041 : ascii = 8'h2C;  // comma
      12'h04E : ascii = 8'h2D;  // minus
      12'h049 : ascii = 8'h2E;  // dot
      12'h04A : ascii = 8'h2F;  // slash
      // digit row, unshifted
      12'h045 : ascii = 8'h30;
      12'h016 : ascii = 8'h31;
      12'h01E : ascii = 8'h32;
      12'h026 : ascii = 8'h33;
      12'h025 : ascii = 8'h34;
      12'h02E : ascii = 8'h35;
      12'h036 : ascii = 8'h36;
      12'h03D : ascii = 8'h37;
      12'h03E : ascii = 8'h38;
      12'h046 : ascii = 8'h39;
      12'h14C : ascii = 8'h3A;  // colon
      12'h04C : ascii = 8'h3B;  // semicolon
      12'h141 : ascii = 8'h3C;  // <
      12'h055 : ascii = 8'h3D;  // =
      12'h149 : ascii = 8'h3E;  // >
      12'h14A : ascii = 8'h3F;  // ?
      12'h11E : ascii = 8'h40;  // @
      // letters with shift held
      12'h11C : ascii = 8'h41;
      12'h132 : ascii = 8'h42;
      12'h121 : ascii = 8'h43;
      12'h123 : ascii = 8'h44;
      12'h124 : ascii = 8'h45;
      12'h12B : ascii = 8'h46;
      12'h134 : ascii = 8'h47;
      12'h133 : ascii = 8'h48;
      12'h143 : ascii = 8'h49;
      12'h13B : ascii = 8'h4A;
      12'h142 : ascii = 8'h4B;
      12'h14B : ascii = 8'h4C;
      12'h13A : ascii = 8'h4D;
      12'h131 : ascii = 8'h4E;
      12'h144 : ascii = 8'h4F;
      12'h14D : ascii = 8'h50;
      12'h115 : ascii = 8'h51;
      12'h12D : ascii = 8'h52;
      12'h11B : ascii = 8'h53;
      12'h12C : ascii = 8'h54;
      12'h13C : ascii = 8'h55;
      12'h12A : ascii = 8'h56;
      12'h11D : ascii = 8'h57;
      12'h122 : ascii = 8'h58;
      12'h135 : ascii = 8'h59;
      12'h11A : ascii = 8'h5A;
      12'h054 : ascii = 8'h5B;  // [
      12'h05D : ascii = 8'h5C;  // backslash
      12'h05B : ascii = 8'h5D;  // ]
      12'h136 : ascii = 8'h5E;  // caret
      12'h14E : ascii = 8'h5F;  // underscore
      12'h00E : ascii = 8'h60;  // grave accent
      // letters without shift
      12'h01C : ascii = 8'h61;
      12'h032 : ascii = 8'h62;
      12'h021 : ascii = 8'h63;
      12'h023 : ascii = 8'h64;
      12'h024 : ascii = 8'h65;
      12'h02B : ascii = 8'h66;
      12'h034 : ascii = 8'h67;
      12'h033 : ascii = 8'h68;
      12'h043 : ascii = 8'h69;
      12'h03B : ascii = 8'h6A;
      12'h042 : ascii = 8'h6B;
      12'h04B : ascii = 8'h6C;
      12'h03A : ascii = 8'h6D;
      12'h031 : ascii = 8'h6E;
      12'h044 : ascii = 8'h6F;
      12'h04D : ascii = 8'h70;
      12'h015 : ascii = 8'h71;
      12'h02D : ascii = 8'h72;
      12'h01B : ascii = 8'h73;
      12'h02C : ascii = 8'h74;
      12'h03C : ascii = 8'h75;
      12'h02A : ascii = 8'h76;
      12'h01D : ascii = 8'h77;
      12'h022 : ascii = 8'h78;
      12'h035 : ascii = 8'h79;
      12'h01A : ascii = 8'h7A;
      12'h154 : ascii = 8'h7B;  // {
      12'h15D : ascii = 8'h7C;  // |
      12'h15B : ascii = 8'h7D;  // }
      12'h10E : ascii = 8'h7E;  // ~
      12'h?71 : ascii = 8'h7F;  // delete, also keypad del
      default : ascii = ASCII_UNLISTED;
    endcase
  end

endmodule

//--- ps2_keyboard_rx.f
logic/key_event_pkg.sv
logic/ps2_protocol_pkg.sv
logic/ps2_frame_receiver.sv
logic/scan_code_tracker.sv
logic/scan_to_ascii.sv
logic/key_event_buffer.sv
logic/ps2_keyboard_rx.sv
verification/ps2_keyboard_rx_properties.sv
verification/ps2_keyboard_rx_tb.sv

//--- verification/ps2_keyboard_rx_patterns.txt
// per record: command, scan byte, expectation, expected key event (hex)
// command 1 full frame, 2 five-bit frame, 3 idle past watchdog, 0 end; expectation 0 none, 1 read, 2 keep
// key event digits: {extended, released, shift_on}, scan, ascii
1 1C 1 01C61
1 12 1 0122E
1 1C 1 11C41
1 F0 0 00000
1 12 1 3122E
1 1C 1 01C61
1 E0 0 00000
1 71 1 4717F
1 F0 0 00000
1 1C 1 21C61
1 45 1 04530
1 16 1 01631
1 3E 1 03E38
1 41 1 0412C
1 4A 1 04A2F
1 52 1 05227
1 05 1 0052E
1 59 1 0592E
1 16 1 11621
1 1E 1 11E40
1 4A 1 14A3F
1 4E 1 14E5F
1 F0 0 00000
1 59 1 3592E
2 1C 0 00000
3 00 0 00000
1 2B 1 02B66
1 1C 2 01C61
1 32 1 03262
0 00 0 00000

//--- verification/ps2_keyboard_rx_properties.sv
// concurrent checks on the host handshake of the keyboard receiver, attached to its top by bind
`timescale 1ns/1ps

module ps2_keyboard_rx_properties
  import key_event_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       key_read,
  input logic       frame_done,  // internal strobe of the top
  input key_event_t key_event,
  input logic       key_ready
);

  // nothing pending straight after reset
  ready_low_after_reset: assert property (@(posedge clk) !reset |=> !key_ready)
    else $error("key_ready is high in the cycle after reset");

  // only the host clears ready
  ready_falls_on_read: assert property (@(posedge clk) disable iff (!reset)
    $fell(key_ready) |-> $past(key_read))
    else $error("key_ready fell without key_read in the previous cycle");

  // held event only changes when a frame completes
  event_held_while_ready: assert property (@(posedge clk) disable iff (!reset)
    (key_ready && !$past(frame_done)) |-> $stable(key_event))
    else $error("key_event changed while key_ready was high and no frame completed");

endmodule

bind ps2_keyboard_rx ps2_keyboard_rx_properties u_properties (
  .clk        (clk),
  .reset      (reset),
  .key_read   (key_read),
  .frame_done (frame_done),
  .key_event  (key_event),
  .key_ready  (key_ready)
);

//--- verification/ps2_keyboard_rx_tb.sv
// testbench for the ps/2 keyboard receiver; replays the pattern file frame by frame and checks each key event
`timescale 1ns/1ps

module ps2_keyboard_rx_tb
  import key_event_pkg::*;
  import ps2_protocol_pkg::*;
();

  localparam int HALF_CYCLES  = 20;   // clk cycles per ps/2 clock half period
  localparam int WAIT_LIMIT   = 200;  // clk cycles before a wait gives up
  localparam int QUIET_CYCLES = 12;   // watch window for a prefix or dropped frame
  localparam int MAX_RECORDS  = 64;

  // pattern commands and expectations
  localparam logic [3:0] CMD_END     = 4'h0;
  localparam logic [3:0] CMD_FRAME   = 4'h1;
  localparam logic [3:0] CMD_PARTIAL = 4'h2;
  localparam logic [3:0] CMD_IDLE    = 4'h3;
  localparam logic [1:0] EXPECT_NONE = 2'd0;
  localparam logic [1:0] EXPECT_READ = 2'd1;

  logic       clk;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       key_read;
  key_event_t key_event;
  logic       key_ready;

  logic [19:0] patterns [0:4*MAX_RECORDS-1];  // four words per record
  logic [15:0] lfsr_state;
  int          checks;
  int          value_errors;
  int          other_errors;   // timeouts and handshake faults
  int          records;

  ps2_keyboard_rx dut0 (
    .clk       (clk),
    .reset     (reset),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .key_read  (key_read),
    .key_event (key_event),
    .key_ready (key_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  //----------------------------------------
  // random numbers
  //----------------------------------------

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic random_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      value      = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  //----------------------------------------
  // keyboard side
  //----------------------------------------

  // start 0, data lsb first, odd parity, stop 1; nbits below 11 cuts the frame short
  task automatic send_frame_bits(input scan_code_t code, input int nbits);
    logic [10:0] wire_bits;
    wire_bits = {1'b1, ~^code, code, 1'b0};
    @(posedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      ps2_data <= wire_bits[i];               // data changes while clock is high
      repeat (HALF_CYCLES) @(posedge clk);
      ps2_clk <= 1'b0;                        // receiver samples on this fall
      repeat (HALF_CYCLES) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    ps2_data <= 1'b1;                         // back to idle
    repeat (HALF_CYCLES) @(posedge clk);
  endtask

  //----------------------------------------
  // host side and checks
  //----------------------------------------

  task automatic wait_key_ready(input logic level, output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < WAIT_LIMIT)
    begin
      @(negedge clk);                          // sample away from the drive edge
      ok = (key_ready === level);
      n++;
    end
    if (!ok)
    begin
      other_errors++;
      $display("%0t: timeout, key_ready did not become %0b within %0d cycles",
               $time, level, WAIT_LIMIT);
    end
  endtask

  task automatic expect_no_event();
    for (int n = 0; n < QUIET_CYCLES; n++)
    begin
      @(negedge clk);
      if (key_ready !== 1'b0)
      begin
        other_errors++;
        $display("%0t: key_ready went high although no key event was due", $time);
      end
    end
  endtask

  // host waits a random time, then pulses key_read for one cycle
  task automatic read_key_event();
    int   delay;
    logic ok;
    random_bits(3, delay);
    for (int n = 0; n < delay; n++)
    begin
      @(negedge clk);
      if (key_ready !== 1'b1)
      begin
        other_errors++;
        $display("%0t: key_ready dropped before the host gave key_read", $time);
      end
    end
    @(posedge clk);
    key_read <= 1'b1;
    @(posedge clk);
    key_read <= 1'b0;
    wait_key_ready(1'b0, ok);  // must fall once the read is seen
  endtask

  task automatic check_event(input string name, input key_event_t expected,
                             input key_event_t actual);
    checks++;
    if (actual !== expected)
    begin
      value_errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_scan(input string name, input scan_code_t expected,
                            input scan_code_t actual);
    checks++;
    if (actual !== expected)
    begin
      value_errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  //----------------------------------------
  // main sequence
  //----------------------------------------

  initial
  begin
    logic [3:0] cmd;
    scan_code_t scan;
    logic [1:0] mode;
    key_event_t expected;
    int         gap;
    logic       ok;
    reset        = 1'b0;
    ps2_clk      = 1'b1;  // lines idle high
    ps2_data     = 1'b1;
    key_read     = 1'b0;
    lfsr_state   = 16'd50;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    records      = 0;
    $readmemh("verification/ps2_keyboard_rx_patterns.txt", patterns);
    repeat (16) @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);

    while (records < MAX_RECORDS && patterns[4*records][3:0] != CMD_END)
    begin
      cmd      = patterns[4*records][3:0];
      scan     = patterns[4*records+1][7:0];
      mode     = patterns[4*records+2][1:0];
      expected = key_event_t'(patterns[4*records+3][18:0]);
      case (cmd)
        CMD_FRAME:   send_frame_bits(scan, FRAME_BITS);
        CMD_PARTIAL: send_frame_bits(scan, 5);
        CMD_IDLE:    repeat (WATCHDOG_CYCLES + 100) @(posedge clk);  // let the watchdog fire
        default:
        begin
          other_errors++;
          $display("pattern record %0d has an unknown command %h", records, cmd);
        end
      endcase
      if (mode == EXPECT_NONE)
        expect_no_event();
      else
      begin
        wait_key_ready(1'b1, ok);
        if (ok)
        begin
          check_event("key_event", expected, key_event);
          check_scan("key_event.scan", scan, key_event.scan);
          if (mode == EXPECT_READ)
            read_key_event();  // otherwise left pending for an overwrite
        end
      end
      random_bits(4, gap);
      repeat (gap + 2) @(posedge clk);  // idle gap between frames
      records++;
    end

    if (records == 0)
    begin
      other_errors++;
      $display("no pattern records could be read");
    end
    $display("records %0d, checks %0d, value errors %0d, other failures %0d",
             records, checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
